// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_top
FILELIST   := sim.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps --top-module $(TOP)
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST) -o sim

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);
  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: bench/rd_checker.sv
`timescale 1ns/1ps
`include "axi_sram_params.svh"

module rd_checker
  import axi_sram_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   arvalid,
  input  logic                   arready,
  input  logic [`AXI_ID_W-1:0]   arid,
  input  logic [`AXI_ADDR_W-1:0] araddr,
  input  logic [7:0]             arlen,
  input  logic [2:0]             arsize,
  input  logic [1:0]             arburst,
  input  logic                   rvalid,
  input  logic                   rready,
  input  logic [`AXI_ID_W-1:0]   rid,
  input  logic [`AXI_DATA_W-1:0] rdata,
  input  logic [1:0]             rresp,
  input  logic                   rlast,
  input  logic                   wrap_up,
  output logic                   report_done,
  output int                     err_count,
  output int                     pending
);
  typedef logic [`AXI_ADDR_W-1:0] byte_addr_t;

  // 4-byte bus
  localparam int bus_size = $clog2(`AXI_DATA_W / 8);

  r_beat_t exp_q[$];
  r_beat_t want;
  int      total_expected = 0;
  int      beats_seen = 0;
  int      outstanding = 0;
  int      value_errors = 0;
  int      other_errors = 0;

  assign err_count = value_errors + other_errors;
  assign pending   = outstanding;

  // word address of beat k
  function automatic logic [`SRAM_AW-1:0] beat_word(input byte_addr_t addr,
      input logic [2:0] size, input logic [1:0] burst, input int k);
    int         step;
    byte_addr_t a;
    step = (int'(size) > bus_size) ? bus_size : int'(size);
    a = addr;
    // FIXED bursts never leave the start word
    if (burst != 2'b00) begin
      a = addr + byte_addr_t'(k << step);
    end
    return a[`AXI_ADDR_W-1:bus_size];
  endfunction

  task automatic expect_burst(input logic [`AXI_ID_W-1:0] id, input byte_addr_t addr,
      input logic [7:0] len, input logic [2:0] size, input logic [1:0] burst);
    r_beat_t beat;
    int      k;
    for (k = 0; k <= int'(len); k++) begin
      beat.id   = id;
      beat.data = tb_top.shadow_mem[beat_word(addr, size, burst, k)];
      beat.last = (k == int'(len));
      exp_q.push_back(beat);
    end
    total_expected += int'(len) + 1;
    outstanding    += int'(len) + 1;
  endtask

  task automatic report_value(input string name, input logic [31:0] exp_val,
      input logic [31:0] got_val);
    value_errors++;
    $display("[FAIL] %0d ns %s: expected %h, got %h", $time, name, exp_val, got_val);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      report_done <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        expect_burst(arid, araddr, arlen, arsize, arburst);
      end
      if (rvalid && rready) begin
        beats_seen++;
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("%0d ns: read beat arrived with no request outstanding (rid %h)",
                   $time, rid);
        end else begin
          want = exp_q.pop_front();
          outstanding--;
          if (rid !== want.id) report_value("rid", 32'(want.id), 32'(rid));
          if (rdata !== want.data) report_value("rdata", want.data, rdata);
          if (rlast !== want.last) report_value("rlast", 32'(want.last), 32'(rlast));
          if (rresp !== 2'b00) report_value("rresp", 32'h0, 32'(rresp));
        end
      end
      if (wrap_up && !report_done) begin
        if (beats_seen != total_expected) begin
          other_errors++;
          $display("beat count wrong: %0d beats seen, %0d expected",
                   beats_seen, total_expected);
        end
        $display("checker: %0d beats of %0d expected, %0d value errors, %0d other errors",
                 beats_seen, total_expected, value_errors, other_errors);
        report_done <= 1'b1;
      end
    end
  end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps
`include "axi_sram_params.svh"

module tb_top;
  localparam int ar_wait_limit = 2000;
  localparam int drain_limit   = 50000;

  logic                   clk;
  logic                   rst_n;
  logic                   arvalid;
  logic                   arready;
  logic [`AXI_ID_W-1:0]   arid;
  logic [`AXI_ADDR_W-1:0] araddr;
  logic [7:0]             arlen;
  logic [2:0]             arsize;
  logic [1:0]             arburst;
  logic                   rvalid;
  logic                   rready;
  logic [`AXI_ID_W-1:0]   rid;
  logic [`AXI_DATA_W-1:0] rdata;
  logic [1:0]             rresp;
  logic                   rlast;
  logic                   wr_en;
  logic [`SRAM_AW-1:0]    wr_addr;
  logic [`AXI_DATA_W-1:0] wr_data;

  // copy of the SRAM contents for the checker
  logic [`AXI_DATA_W-1:0] shadow_mem [1 << `SRAM_AW];

  logic bp_en;
  logic wrap_up;
  logic report_done;
  int   err_count;
  int   pending;
  bit   timed_out;

  clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  axi_sram_rd_top UUT (
    .clk(clk), .rst_n(rst_n),
    .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr),
    .arlen(arlen), .arsize(arsize), .arburst(arburst),
    .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata),
    .rresp(rresp), .rlast(rlast),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  rd_checker chk (
    .clk(clk), .rst_n(rst_n),
    .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr),
    .arlen(arlen), .arsize(arsize), .arburst(arburst),
    .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata),
    .rresp(rresp), .rlast(rlast),
    .wrap_up(wrap_up), .report_done(report_done),
    .err_count(err_count), .pending(pending)
  );

  // rready low about 40 percent of the time once back-pressure is on
  initial begin
    rready = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        rready <= 1'b0;
      end else if (bp_en) begin
        rready <= ($urandom_range(99) >= 40);
      end else begin
        rready <= 1'b1;
      end
    end
  end

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end
  endtask

  task automatic fill_memory();
    logic [`AXI_DATA_W-1:0] word;
    int                     a;
    for (a = 0; a < (1 << `SRAM_AW); a++) begin
      word          = $urandom;
      shadow_mem[a] = word;
      wr_en   <= 1'b1;
      wr_addr <= a[`SRAM_AW-1:0];
      wr_data <= word;
      @(posedge clk);
    end
    wr_en <= 1'b0;
  endtask

  task automatic send_ar(input logic [`AXI_ID_W-1:0] id, input logic [`AXI_ADDR_W-1:0] addr,
      input logic [7:0] len, input logic [2:0] size, input logic [1:0] burst);
    int waited;
    arvalid <= 1'b1;
    arid    <= id;
    araddr  <= addr;
    arlen   <= len;
    arsize  <= size;
    arburst <= burst;
    waited = 0;
    @(posedge clk);
    while (!arready && waited < ar_wait_limit) begin
      @(posedge clk);
      waited++;
    end
    arvalid <= 1'b0;
    if (!arready) begin
      timed_out = 1'b1;
      $display("timeout: arready stayed low for %0d cycles", ar_wait_limit);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    while (pending != 0 && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0) begin
      timed_out = 1'b1;
      $display("timeout: %0d read beats never arrived", pending);
    end
    // room for a late or duplicated beat to show up
    repeat (20) @(posedge clk);
  endtask

  initial begin
    int n;
    void'($urandom(32'hca10));
    arvalid   = 1'b0;
    arid      = '0;
    araddr    = '0;
    arlen     = '0;
    arsize    = '0;
    arburst   = '0;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    bp_en     = 1'b0;
    wrap_up   = 1'b0;
    timed_out = 1'b0;

    wait_reset();
    if (!timed_out) begin
      fill_memory();
    end
    // single beats
    for (n = 0; n < 20 && !timed_out; n++) begin
      send_ar(4'($urandom), 12'($urandom), 8'd0, 3'd2, 2'd1);
    end
    // full-size INCR bursts
    for (n = 0; n < 20 && !timed_out; n++) begin
      send_ar(4'($urandom), 12'($urandom), 8'($urandom_range(15)), 3'd2, 2'd1);
    end
    // FIXED, then narrow and oversized sizes, WRAP code steps like INCR
    for (n = 0; n < 24 && !timed_out; n++) begin
      send_ar(4'($urandom), 12'($urandom), 8'($urandom_range(15)), 3'(n % 4),
              (n < 8) ? 2'd0 : ((n < 16) ? 2'd1 : 2'd2));
    end
    // back to back with distinct ids
    for (n = 0; n < 16 && !timed_out; n++) begin
      send_ar(4'(n), 12'($urandom), 8'($urandom_range(3)), 3'd2, 2'd1);
    end
    bp_en <= 1'b1;
    for (n = 0; n < 200 && !timed_out; n++) begin
      repeat ($urandom_range(2)) @(posedge clk);
      send_ar(4'($urandom), 12'($urandom), 8'($urandom_range(15)),
              3'($urandom_range(3)), 2'($urandom_range(2)));
    end
    if (!timed_out) begin
      wait_drain();
    end

    wrap_up <= 1'b1;
    n = 0;
    @(posedge clk);
    while (!report_done && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (!report_done) begin
      $display("checker never printed its counts");
    end
    if (err_count == 0 && !timed_out && report_done) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+verilog
verilog/axi_sram_pkg.sv
verilog/sync_fifo.sv
verilog/axi_sram_rd_seq.sv
verilog/sram_rd_pipe.sv
verilog/axi_sram_rd_top.sv
bench/clk_gen.sv
bench/rd_checker.sv
bench/tb_top.sv

// File: verilog/axi_sram_params.svh
`ifndef AXI_SRAM_PARAMS_SVH
`define AXI_SRAM_PARAMS_SVH

// AXI side widths
`define AXI_ADDR_W 12
`define AXI_DATA_W 32
`define AXI_ID_W 4

// one SRAM word per 4-byte beat
`define SRAM_AW 10

// queue depths
`define AR_FIFO_DEPTH 4
`define R_FIFO_DEPTH 8

`endif

// File: verilog/axi_sram_pkg.sv
`include "axi_sram_params.svh"

package axi_sram_pkg;

  // log2 of the bus byte width
  localparam logic [2:0] max_size = 3'($clog2(`AXI_DATA_W / 8));

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } ar_req_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic                 last;
  } sram_tag_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic                   last;
  } r_beat_t;

endpackage

// File: verilog/axi_sram_rd_seq.sv
`timescale 1ns/1ps
`include "axi_sram_params.svh"

module axi_sram_rd_seq
  import axi_sram_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,

  // request side, head of the AR queue
  input  logic                req_valid,
  output logic                req_ready,
  input  ar_req_t             req,

  // single-word SRAM commands
  output logic                cmd_valid,
  input  logic                cmd_ready,
  output logic [`SRAM_AW-1:0] cmd_addr,
  output sram_tag_t           cmd_tag
);
  typedef enum logic {
    st_idle,
    st_burst
  } state_t;

  state_t                   state;
  state_t                   state_next;

  logic                     req_ready_next;
  logic                     cmd_valid_next;

  logic [`AXI_ADDR_W-1:0]   byte_addr;
  logic [`AXI_ADDR_W-1:0]   byte_addr_next;
  logic [`AXI_ADDR_W-1:0]   beat_bytes;

  logic [`AXI_ID_W-1:0]     burst_id;
  logic [`AXI_ID_W-1:0]     burst_id_next;

  logic [7:0]               beats_left;
  logic [7:0]               beats_left_next;

  logic [2:0]               beat_size;
  logic [2:0]               beat_size_next;

  logic [1:0]               burst_kind;
  logic [1:0]               burst_kind_next;

  logic                     last_beat;
  logic                     last_beat_next;

  // byte to word address
  assign cmd_addr = byte_addr[`AXI_ADDR_W-1:max_size];
  assign cmd_tag  = '{id: burst_id, last: last_beat};

  assign beat_bytes = {{(`AXI_ADDR_W - 1){1'b0}}, 1'b1} << beat_size;

  always_comb begin
    state_next      = state;
    req_ready_next  = req_ready;
    cmd_valid_next  = cmd_valid;
    byte_addr_next  = byte_addr;
    burst_id_next   = burst_id;
    beats_left_next = beats_left;
    beat_size_next  = beat_size;
    burst_kind_next = burst_kind;
    last_beat_next  = last_beat;

    case (state)
      st_idle: begin
        req_ready_next = 1'b1;

        if (req_valid && req_ready) begin
          state_next      = st_burst;
          req_ready_next  = 1'b0;
          cmd_valid_next  = 1'b1;

          byte_addr_next  = req.addr;
          burst_id_next   = req.id;
          beats_left_next = req.len;
          // no beats wider than the bus
          beat_size_next  = (req.size < max_size) ? req.size : max_size;
          burst_kind_next = req.burst;
          last_beat_next  = (req.len == 8'd0);
        end
      end

      st_burst: begin
        if (cmd_valid && cmd_ready) begin
          beats_left_next = beats_left - 8'd1;
          last_beat_next  = (beats_left == 8'd1);

          // FIXED keeps the address, everything else steps
          if (burst_kind != 2'b00) begin
            byte_addr_next = byte_addr + beat_bytes;
          end

          if (last_beat) begin
            state_next     = st_idle;
            cmd_valid_next = 1'b0;
            req_ready_next = 1'b1;
          end
        end
      end

      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      req_ready <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      state     <= state_next;
      req_ready <= req_ready_next;
      cmd_valid <= cmd_valid_next;
    end
  end

  // burst context
  always_ff @(posedge clk) begin
    byte_addr  <= byte_addr_next;
    burst_id   <= burst_id_next;
    beats_left <= beats_left_next;
    beat_size  <= beat_size_next;
    burst_kind <= burst_kind_next;
    last_beat  <= last_beat_next;
  end

endmodule

// File: verilog/axi_sram_rd_top.sv
`timescale 1ns/1ps
`include "axi_sram_params.svh"

module axi_sram_rd_top
  import axi_sram_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   arvalid,
  output logic                   arready,
  input  logic [`AXI_ID_W-1:0]   arid,
  input  logic [`AXI_ADDR_W-1:0] araddr,
  input  logic [7:0]             arlen,
  input  logic [2:0]             arsize,
  input  logic [1:0]             arburst,

  output logic                   rvalid,
  input  logic                   rready,
  output logic [`AXI_ID_W-1:0]   rid,
  output logic [`AXI_DATA_W-1:0] rdata,
  output logic [1:0]             rresp,
  output logic                   rlast,

  input  logic                   wr_en,
  input  logic [`SRAM_AW-1:0]    wr_addr,
  input  logic [`AXI_DATA_W-1:0] wr_data
);
  ar_req_t                ar_din;
  ar_req_t                ar_head;
  logic                   ar_full;
  logic                   ar_empty;
  logic                   req_ready;

  logic                   cmd_valid;
  logic                   cmd_ready;
  logic [`SRAM_AW-1:0]    cmd_addr;
  sram_tag_t              cmd_tag;

  logic                   resp_valid;
  logic [`AXI_DATA_W-1:0] resp_data;
  sram_tag_t              resp_tag;

  r_beat_t                r_din;
  r_beat_t                r_head;
  logic                   r_full;
  logic                   r_empty;

  assign ar_din  = '{id: arid, addr: araddr, len: arlen, size: arsize, burst: arburst};
  assign arready = !ar_full;

  assign r_din  = '{id: resp_tag.id, data: resp_data, last: resp_tag.last};
  assign rvalid = !r_empty;
  assign rid    = r_head.id;
  assign rdata  = r_head.data;
  assign rlast  = r_head.last;
  // always OKAY
  assign rresp  = 2'b00;

  sync_fifo #(.payload_t(ar_req_t), .DEPTH(`AR_FIFO_DEPTH)) ar_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(arvalid && arready), .din(ar_din), .full(ar_full),
    .pop(!ar_empty && req_ready), .dout(ar_head), .empty(ar_empty)
  );

  axi_sram_rd_seq seq (
    .clk(clk), .rst_n(rst_n),
    .req_valid(!ar_empty), .req_ready(req_ready), .req(ar_head),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_addr(cmd_addr), .cmd_tag(cmd_tag)
  );

  sram_rd_pipe pipe (
    .clk(clk), .rst_n(rst_n),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_addr(cmd_addr), .cmd_tag(cmd_tag),
    .resp_valid(resp_valid), .resp_ready(!r_full), .resp_data(resp_data),
    .resp_tag(resp_tag)
  );

  sync_fifo #(.payload_t(r_beat_t), .DEPTH(`R_FIFO_DEPTH)) r_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(resp_valid && !r_full), .din(r_din), .full(r_full),
    .pop(rvalid && rready), .dout(r_head), .empty(r_empty)
  );

endmodule

// File: verilog/sram_rd_pipe.sv
`timescale 1ns/1ps
`include "axi_sram_params.svh"

module sram_rd_pipe
  import axi_sram_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // plain write strobe for loading
  input  logic                  wr_en,
  input  logic [`SRAM_AW-1:0]   wr_addr,
  input  logic [`AXI_DATA_W-1:0] wr_data,

  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic [`SRAM_AW-1:0]   cmd_addr,
  input  sram_tag_t             cmd_tag,

  output logic                  resp_valid,
  input  logic                  resp_ready,
  output logic [`AXI_DATA_W-1:0] resp_data,
  output sram_tag_t             resp_tag
);
  logic [`AXI_DATA_W-1:0] mem [1 << `SRAM_AW];

  logic                   stall;

  // stage 1, array read
  logic                   s1_valid;
  logic [`AXI_DATA_W-1:0] s1_data;
  sram_tag_t              s1_tag;

  // stage 2, output register
  logic                   s2_valid;
  logic [`AXI_DATA_W-1:0] s2_data;
  sram_tag_t              s2_tag;

  // output held and not taken, so nothing moves
  assign stall     = s2_valid && !resp_ready;
  assign cmd_ready = !stall;

  assign resp_valid = s2_valid;
  assign resp_data  = s2_data;
  assign resp_tag   = s2_tag;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      s1_data <= mem[cmd_addr];
      s1_tag  <= cmd_tag;
      s2_data <= s1_data;
      s2_tag  <= s1_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= cmd_valid;
      s2_valid <= s1_valid;
    end
  end

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t din,
  output logic     full,
  input  logic     pop,
  output payload_t dout,
  output logic     empty
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t             mem [DEPTH];
  logic     [PTR_W-1:0] wr_ptr;
  logic     [PTR_W-1:0] rd_ptr;
  logic     [CNT_W-1:0] count;
  logic     [CNT_W-1:0] count_next;
  logic                 do_push;
  logic                 do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // head is visible without a read cycle
  assign dout = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (do_push && !do_pop) begin
      count_next = count + CNT_W'(1);
    end else if (do_pop && !do_push) begin
      count_next = count - CNT_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      // hold off writers while in reset
      full   <= 1'b1;
      empty  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      count <= count_next;
      full  <= (count_next == CNT_W'(DEPTH));
      empty <= (count_next == '0);
    end
  end

endmodule
